//--- rasterPkg.sv
// Shared constants of the fragment shading pipeline
// Function codes, wrap modes and fixed stage latencies
// Referenced by scoped name from the RTL and the testbench
package rasterPkg;

    ///////////////////////////////////////////////////////////////////////
    // Texture environment functions
    ///////////////////////////////////////////////////////////////////////

    // Width of the function code
    parameter int TEX_ENV_FUNC_WIDTH = 3;

    // Texel passed through unchanged
    parameter logic [TEX_ENV_FUNC_WIDTH-1:0] REPLACE = 3'd0;
    // Texel times primary colour, all channels
    parameter logic [TEX_ENV_FUNC_WIDTH-1:0] MODULATE = 3'd1;
    // Texel over primary, weighted by texel alpha
    parameter logic [TEX_ENV_FUNC_WIDTH-1:0] DECAL = 3'd2;
    // Primary towards env colour, weighted by texel
    parameter logic [TEX_ENV_FUNC_WIDTH-1:0] BLEND = 3'd3;
    // Saturating sum of texel and primary
    parameter logic [TEX_ENV_FUNC_WIDTH-1:0] ADD = 3'd4;
    // Codes 5 to 7 are unassigned and act as REPLACE

    ///////////////////////////////////////////////////////////////////////
    // Coordinate wrap modes, one bit per axis
    ///////////////////////////////////////////////////////////////////////

    // Fraction bits kept, integer part dropped
    parameter logic REPEAT = 1'b0;
    // Clamped into [0, 1.0)
    parameter logic CLAMP_TO_EDGE = 1'b1;

    ///////////////////////////////////////////////////////////////////////
    // Pipeline latencies in clock cycles
    ///////////////////////////////////////////////////////////////////////

    // Texture memory, read address register to data
    parameter int TEXEL_LATENCY = 6;
    // Texture environment combiner
    parameter int TEXENV_LATENCY = 2;
    // Whole mapping unit, fragment in to colour out
    // Coordinate stage + texel fetch + combiner
    parameter int TMU_LATENCY = 1 + TEXEL_LATENCY + TEXENV_LATENCY;

endpackage

//--- ValueDelay.sv
// Fixed-depth delay line for payload data
// Aligns a value with a slower parallel path, no reset
`timescale 1ns/1ps

module ValueDelay
#(
    parameter int VALUE_SIZE = 32,
    parameter int DELAY = 1
)
(
    input  logic                    aclk,
    input  logic [VALUE_SIZE-1:0]   in,
    output logic [VALUE_SIZE-1:0]   out
);

    // One register per cycle of delay
    logic [VALUE_SIZE-1:0] stages [DELAY];

    always_ff @(posedge aclk)
    begin
        stages[0] <= in;
        // Shift towards the tail
        for (int i = 1; i < DELAY; i++)
        begin
            stages[i] <= stages[i - 1];
        end
    end

    assign out = stages[DELAY - 1];

endmodule

//--- TextureMemory.sv
// On-chip texture store of 2^TEX_SIZE_LOG2 squared RGBA texels
// Write port loads the texture, read port returns a texel with a
// fixed latency of TEXEL_LATENCY cycles after the address register
`timescale 1ns/1ps

module TextureMemory
#(
    parameter int SUB_PIXEL_WIDTH = 8,
    parameter int TEX_SIZE_LOG2 = 4,
    localparam int PIXEL_WIDTH = 4 * SUB_PIXEL_WIDTH,
    localparam int ADDR_WIDTH = 2 * TEX_SIZE_LOG2
)
(
    input  logic                        aclk,

    // Texture load, T index in the upper half of the address
    input  logic                        writeEnable,
    input  logic [ADDR_WIDTH-1:0]       writeAddress,
    input  logic [PIXEL_WIDTH-1:0]      writeData,

    // Texel request, coordinates with 15 fraction bits
    input  logic [15:0]                 readS,
    input  logic [15:0]                 readT,

    // Texel response
    output logic [PIXEL_WIDTH-1:0]      readData
);

    localparam int TEX_WORDS = 2 ** ADDR_WIDTH;
    // Index register and array read register come first
    localparam int PAD_DELAY = rasterPkg::TEXEL_LATENCY - 2;

    logic [PIXEL_WIDTH-1:0]     texels [TEX_WORDS];
    logic [ADDR_WIDTH-1:0]      readAddress;
    logic [PIXEL_WIDTH-1:0]     readWord;

    ///////////////////////////////////////////////////////////////////////
    // Write port
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (writeEnable)
        begin
            texels[writeAddress] <= writeData;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Read port
    ///////////////////////////////////////////////////////////////////////

    // Nearest texel, top fraction bits below the integer bit
    always_ff @(posedge aclk)
    begin
        readAddress <= {readT[14 -: TEX_SIZE_LOG2], readS[14 -: TEX_SIZE_LOG2]};
    end

    // Registered array read
    always_ff @(posedge aclk)
    begin
        readWord <= texels[readAddress];
    end

    // Remaining cycles of the external buffer latency
    ValueDelay #(
        .VALUE_SIZE(PIXEL_WIDTH),
        .DELAY(PAD_DELAY)
    ) readPad (
        .aclk(aclk),
        .in(readWord),
        .out(readData)
    );

endmodule

//--- TexEnv.sv
// Texture environment combiner for RGBA colours
// Mixes texel, primary colour and env colour as selected by func
// Two register stages, colour valid TEXENV_LATENCY cycles after input
`timescale 1ns/1ps

module TexEnv
#(
    parameter int SUB_PIXEL_WIDTH = 8,
    localparam int PIXEL_WIDTH = 4 * SUB_PIXEL_WIDTH
)
(
    input  logic                                        aclk,

    // Function select, held steady while fragments are in flight
    input  logic [rasterPkg::TEX_ENV_FUNC_WIDTH-1:0]    func,

    input  logic [PIXEL_WIDTH-1:0]                      texSrcColor,
    input  logic [PIXEL_WIDTH-1:0]                      primaryColor,
    input  logic [PIXEL_WIDTH-1:0]                      envColor,

    output logic [PIXEL_WIDTH-1:0]                      color
);

    // RGBA order, red in the top channel, alpha in the low channel
    localparam int ALPHA_CHANNEL = 0;

    // Texel alpha weights DECAL on every channel
    logic [SUB_PIXEL_WIDTH-1:0] texAlpha;

    assign texAlpha = texSrcColor[ALPHA_CHANNEL * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH];

    for (genvar ch = 0; ch < 4; ch++)
    begin : gChannel
        localparam logic [SUB_PIXEL_WIDTH-1:0] CH_MAX = '1;
        localparam bit IS_ALPHA = (ch == ALPHA_CHANNEL);

        logic [SUB_PIXEL_WIDTH-1:0]     tex;
        logic [SUB_PIXEL_WIDTH-1:0]     prim;
        logic [SUB_PIXEL_WIDTH-1:0]     env;
        logic [2*SUB_PIXEL_WIDTH-1:0]   modProduct;
        logic [2*SUB_PIXEL_WIDTH-1:0]   decalSum;
        logic [2*SUB_PIXEL_WIDTH-1:0]   blendSum;
        logic [SUB_PIXEL_WIDTH:0]       addSum;

        // Stage one results
        logic [SUB_PIXEL_WIDTH-1:0]     s1Tex;
        logic [SUB_PIXEL_WIDTH-1:0]     s1Prim;
        logic [SUB_PIXEL_WIDTH-1:0]     s1Mod;
        logic [SUB_PIXEL_WIDTH-1:0]     s1Decal;
        logic [SUB_PIXEL_WIDTH-1:0]     s1Blend;
        logic [SUB_PIXEL_WIDTH:0]       s1Add;

        // Stage two result
        logic [SUB_PIXEL_WIDTH-1:0]     s2Color;

        assign tex  = texSrcColor[ch * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH];
        assign prim = primaryColor[ch * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH];
        assign env  = envColor[ch * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH];

        // Full width products, top half taken as the result
        assign modProduct = tex * prim;
        // Sum never exceeds max * max, so no carry out
        assign decalSum = tex * texAlpha + prim * (CH_MAX - texAlpha);
        assign blendSum = prim * (CH_MAX - tex) + env * tex;
        // Extra bit keeps the overflow for saturation
        assign addSum = tex + prim;

        ///////////////////////////////////////////////////////////////////
        // Stage one, products and sums
        ///////////////////////////////////////////////////////////////////
        always_ff @(posedge aclk)
        begin
            s1Tex   <= tex;
            s1Prim  <= prim;
            s1Mod   <= modProduct[SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH];
            s1Decal <= decalSum[SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH];
            s1Blend <= blendSum[SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH];
            s1Add   <= addSum;
        end

        ///////////////////////////////////////////////////////////////////
        // Stage two, select and saturate
        ///////////////////////////////////////////////////////////////////
        always_ff @(posedge aclk)
        begin
            case (func)
                rasterPkg::MODULATE:
                begin
                    s2Color <= s1Mod;
                end
                rasterPkg::DECAL:
                begin
                    // Alpha straight from the primary colour
                    s2Color <= IS_ALPHA ? s1Prim : s1Decal;
                end
                rasterPkg::BLEND:
                begin
                    s2Color <= IS_ALPHA ? s1Mod : s1Blend;
                end
                rasterPkg::ADD:
                begin
                    if (IS_ALPHA)
                    begin
                        s2Color <= s1Mod;
                    end
                    else
                    begin
                        // Clip at channel max
                        s2Color <= s1Add[SUB_PIXEL_WIDTH] ? CH_MAX
                                                          : s1Add[SUB_PIXEL_WIDTH-1:0];
                    end
                end
                // REPLACE and unassigned codes
                default:
                begin
                    s2Color <= s1Tex;
                end
            endcase
        end

        assign color[ch * SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH] = s2Color;
    end

endmodule

//--- TextureMappingUnit.sv
// Texture mapping unit of the fragment pipeline
// Clamps the coordinates, requests the texel, combines it with the
// primary colour and emits the colour TMU_LATENCY cycles later
`timescale 1ns/1ps

module TextureMappingUnit
#(
    parameter int SUB_PIXEL_WIDTH = 8,
    parameter int TEX_SIZE_LOG2 = 4,
    localparam int PIXEL_WIDTH = 4 * SUB_PIXEL_WIDTH
)
(
    input  logic                                        aclk,
    input  logic                                        reset,

    // Configuration, steady while fragments are in flight
    input  logic [rasterPkg::TEX_ENV_FUNC_WIDTH-1:0]    confFunc,
    input  logic                                        confTextureClampS,
    input  logic                                        confTextureClampT,
    input  logic [PIXEL_WIDTH-1:0]                      confTextureEnvColor,

    // Texture memory access
    output logic [15:0]                                 texelS,
    output logic [15:0]                                 texelT,
    input  logic [PIXEL_WIDTH-1:0]                      texel,

    // Fragment in
    input  logic [PIXEL_WIDTH-1:0]                      primaryColor,
    input  logic [31:0]                                 textureS,
    input  logic [31:0]                                 textureT,
    input  logic                                        fragmentValid,

    // Fragment out
    output logic [PIXEL_WIDTH-1:0]                      fragmentColor,
    output logic                                        fragmentColorValid
);

    // Nearest neighbour, so the bits below the texel index are dropped
    localparam logic [15:0] TEXEL_MASK = 16'hffff << (15 - TEX_SIZE_LOG2);

    // Sign in bit 23, 1.0 at bit 15
    function automatic logic [15:0] clampTexture(input logic [23:0] texCoord,
                                                 input logic mode);
        logic [15:0] result;
        result = texCoord[15:0];
        if (mode != rasterPkg::REPEAT)
        begin
            if (texCoord[23])
            begin
                // Below zero
                result = 16'h0000;
            end
            else if (texCoord[22:15] != '0)
            begin
                // 1.0 or more, last texel
                result = 16'h7fff;
            end
        end
        return result;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Stage 0, coordinates and texel request
    ///////////////////////////////////////////////////////////////////////
    logic [PIXEL_WIDTH-1:0] step0PrimaryColor;

    always_ff @(posedge aclk)
    begin
        texelS <= clampTexture(textureS[23:0], confTextureClampS) & TEXEL_MASK;
        texelT <= clampTexture(textureT[23:0], confTextureClampT) & TEXEL_MASK;
        step0PrimaryColor <= primaryColor;
    end

    ///////////////////////////////////////////////////////////////////////
    // Wait for the texel
    ///////////////////////////////////////////////////////////////////////
    logic [PIXEL_WIDTH-1:0] step1PrimaryColor;

    ValueDelay #(
        .VALUE_SIZE(PIXEL_WIDTH),
        .DELAY(rasterPkg::TEXEL_LATENCY)
    ) primaryColorDelay (
        .aclk(aclk),
        .in(step0PrimaryColor),
        .out(step1PrimaryColor)
    );

    ///////////////////////////////////////////////////////////////////////
    // Texture environment, output straight from the combiner
    ///////////////////////////////////////////////////////////////////////
    TexEnv #(
        .SUB_PIXEL_WIDTH(SUB_PIXEL_WIDTH)
    ) texEnv (
        .aclk(aclk),
        .func(confFunc),
        .texSrcColor(texel),
        .primaryColor(step1PrimaryColor),
        .envColor(confTextureEnvColor),
        .color(fragmentColor)
    );

    // Valid strobe, one bit per pipeline stage
    logic [rasterPkg::TMU_LATENCY-1:0] validPipe;

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            validPipe <= '0;
        end
        else
        begin
            validPipe <= {validPipe[rasterPkg::TMU_LATENCY-2:0], fragmentValid};
        end
    end

    assign fragmentColorValid = validPipe[rasterPkg::TMU_LATENCY-1];

endmodule

//--- FragmentShadingUnit.sv
// Fragment colouring stage with one texture unit
// Joins the mapping unit with its texture memory
// Fragment colour is valid TMU_LATENCY cycles after the fragment
`timescale 1ns/1ps

module FragmentShadingUnit
#(
    parameter int SUB_PIXEL_WIDTH = 8,
    parameter int TEX_SIZE_LOG2 = 4,
    localparam int PIXEL_WIDTH = 4 * SUB_PIXEL_WIDTH,
    localparam int ADDR_WIDTH = 2 * TEX_SIZE_LOG2
)
(
    input  logic                                        aclk,
    input  logic                                        reset,

    // Configuration
    input  logic [rasterPkg::TEX_ENV_FUNC_WIDTH-1:0]    confFunc,
    input  logic                                        confTextureClampS,
    input  logic                                        confTextureClampT,
    input  logic [PIXEL_WIDTH-1:0]                      confTextureEnvColor,

    // Fragment in
    input  logic                                        fragmentValid,
    input  logic [PIXEL_WIDTH-1:0]                      primaryColor,
    input  logic [31:0]                                 textureS,
    input  logic [31:0]                                 textureT,

    // Texture load
    input  logic                                        texWriteEnable,
    input  logic [ADDR_WIDTH-1:0]                       texWriteAddress,
    input  logic [PIXEL_WIDTH-1:0]                      texWriteData,

    // Fragment out
    output logic                                        fragmentColorValid,
    output logic [PIXEL_WIDTH-1:0]                      fragmentColor
);

    // Texel request and response
    logic [15:0]                texelS;
    logic [15:0]                texelT;
    logic [PIXEL_WIDTH-1:0]     texel;

    TextureMappingUnit #(
        .SUB_PIXEL_WIDTH(SUB_PIXEL_WIDTH),
        .TEX_SIZE_LOG2(TEX_SIZE_LOG2)
    ) tmu (
        .aclk(aclk),
        .reset(reset),
        .confFunc(confFunc),
        .confTextureClampS(confTextureClampS),
        .confTextureClampT(confTextureClampT),
        .confTextureEnvColor(confTextureEnvColor),
        .texelS(texelS),
        .texelT(texelT),
        .texel(texel),
        .primaryColor(primaryColor),
        .textureS(textureS),
        .textureT(textureT),
        .fragmentValid(fragmentValid),
        .fragmentColor(fragmentColor),
        .fragmentColorValid(fragmentColorValid)
    );

    TextureMemory #(
        .SUB_PIXEL_WIDTH(SUB_PIXEL_WIDTH),
        .TEX_SIZE_LOG2(TEX_SIZE_LOG2)
    ) texMem (
        .aclk(aclk),
        .writeEnable(texWriteEnable),
        .writeAddress(texWriteAddress),
        .writeData(texWriteData),
        .readS(texelS),
        .readT(texelT),
        .readData(texel)
    );

endmodule

//--- tbFragmentShading.sv
// Self-checking testbench for the fragment shading unit
// Loads a random texture, issues fragments under each texture function
// and wrap mode, and checks colour and valid strobe against a model
`timescale 1ns/1ps

module tbFragmentShading;

    localparam int TEX_LOG2 = 4;
    localparam int TEX_SIDE = 2 ** TEX_LOG2;
    localparam int LAT = rasterPkg::TMU_LATENCY;

    logic           aclk;
    logic           reset;
    logic [2:0]     confFunc;
    logic           confTextureClampS;
    logic           confTextureClampT;
    logic [31:0]    confTextureEnvColor;
    logic           fragmentValid;
    logic [31:0]    primaryColor;
    logic [31:0]    textureS;
    logic [31:0]    textureT;
    logic           texWriteEnable;
    logic [7:0]     texWriteAddress;
    logic [31:0]    texWriteData;
    logic           fragmentColorValid;
    logic [31:0]    fragmentColor;

    // Model state and bookkeeping
    logic [31:0]    lfsrState = 32'h50aab0bf;
    logic [31:0]    texModel [TEX_SIDE * TEX_SIDE];
    logic [31:0]    expColors [$];
    int             expTags [$];
    int             edgeCount = 0;
    int             issued = 0;
    int             resultCount = 0;
    int             checks = 0;
    int             errors = 0;

    FragmentShadingUnit #(.SUB_PIXEL_WIDTH(8), .TEX_SIZE_LOG2(TEX_LOG2)) UUT (
        .aclk(aclk), .reset(reset),
        .confFunc(confFunc), .confTextureClampS(confTextureClampS),
        .confTextureClampT(confTextureClampT), .confTextureEnvColor(confTextureEnvColor),
        .fragmentValid(fragmentValid), .primaryColor(primaryColor),
        .textureS(textureS), .textureT(textureT),
        .texWriteEnable(texWriteEnable), .texWriteAddress(texWriteAddress),
        .texWriteData(texWriteData),
        .fragmentColorValid(fragmentColorValid), .fragmentColor(fragmentColor)
    );

    initial
    begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    always @(posedge aclk)
    begin
        edgeCount <= edgeCount + 1;
    end

    ///////////////////////////////////////////////////////////////////////
    // Reference model
    ///////////////////////////////////////////////////////////////////////

    // Taps 32 22 2 1, one step per bit
    function automatic logic [31:0] nextBits(input int count);
        logic [31:0] result;
        logic fb;
        result = '0;
        for (int i = 0; i < count; i++)
        begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            result = {result[30:0], fb};
        end
        return result;
    endfunction

    // Texel index on one axis
    function automatic int texIndex(input logic [31:0] coord, input logic mode);
        logic [15:0] c;
        c = coord[15:0];
        if (mode == rasterPkg::CLAMP_TO_EDGE)
        begin
            if (coord[23])
                c = 16'h0000;
            else if (coord[23:0] >= 24'h008000)
                c = 16'h7fff;
        end
        return int'(c >> (15 - TEX_LOG2)) % TEX_SIDE;
    endfunction

    function automatic int mul8(input int x, input int y);
        return (x * y) / 256;
    endfunction

    // One channel, alpha is channel 0
    function automatic logic [7:0] refChannel(input logic [2:0] func, input int ch,
                                              input int tex, input int prim,
                                              input int env, input int texA);
        int r;
        case (func)
            rasterPkg::MODULATE: r = mul8(tex, prim);
            rasterPkg::DECAL:
                r = (ch == 0) ? prim : (tex * texA + prim * (255 - texA)) / 256;
            rasterPkg::BLEND:
                r = (ch == 0) ? mul8(tex, prim) : (prim * (255 - tex) + env * tex) / 256;
            rasterPkg::ADD:
                r = (ch == 0) ? mul8(tex, prim) : ((tex + prim > 255) ? 255 : tex + prim);
            default: r = tex;
        endcase
        return 8'(r);
    endfunction

    function automatic logic [31:0] refColor(input logic [2:0] func, input logic [31:0] tex,
                                             input logic [31:0] prim, input logic [31:0] env);
        logic [31:0] result;
        for (int ch = 0; ch < 4; ch++)
        begin
            result[ch*8 +: 8] = refChannel(func, ch, int'(tex[ch*8 +: 8]),
                                           int'(prim[ch*8 +: 8]), int'(env[ch*8 +: 8]),
                                           int'(tex[7:0]));
        end
        return result;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Output checker
    ///////////////////////////////////////////////////////////////////////

    // Value held now is what a downstream register takes at the next edge
    always @(negedge aclk)
    begin
        logic expValid;
        logic [31:0] expColor;
        if (!reset)
        begin
            expValid = (expTags.size() > 0) && (expTags[0] == edgeCount + 1 - LAT);
            expColor = expValid ? expColors[0] : 32'h0;
            checks++;
            assert (fragmentColorValid === expValid)
            else
            begin
                errors++;
                $display("Mismatch at %0t: fragmentColorValid expected %0b, got %0b",
                         $time, expValid, fragmentColorValid);
            end
            if (expValid)
            begin
                void'(expTags.pop_front());
                void'(expColors.pop_front());
                resultCount++;
                assert (fragmentColor === expColor)
                else
                begin
                    errors++;
                    $display("Mismatch at %0t: fragmentColor expected %08h, got %08h",
                             $time, expColor, fragmentColor);
                end
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    ///////////////////////////////////////////////////////////////////////
    task automatic idleCycles(input int n);
        repeat (n)
        begin
            @(negedge aclk);
            fragmentValid = 1'b0;
        end
    endtask

    // Wait until every issued fragment has come out
    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while (expTags.size() > 0 && cycles < 4 * LAT)
        begin
            @(negedge aclk);
            fragmentValid = 1'b0;
            cycles++;
        end
        if (expTags.size() > 0)
        begin
            errors++;
            $display("Timeout: %0d fragments never came out of the pipeline", expTags.size());
        end
    endtask

    task automatic setConfig(input logic [2:0] func, input logic clampS, input logic clampT,
                             input logic [31:0] env);
        waitDrain();
        confFunc = func;
        confTextureClampS = clampS;
        confTextureClampT = clampT;
        confTextureEnvColor = env;
    endtask

    task automatic loadTexture();
        for (int a = 0; a < TEX_SIDE * TEX_SIDE; a++)
        begin
            @(negedge aclk);
            texWriteEnable = 1'b1;
            texWriteAddress = 8'(a);
            texWriteData = nextBits(32);
            texModel[a] = texWriteData;
        end
        @(negedge aclk);
        texWriteEnable = 1'b0;
    endtask

    task automatic issueFragment(input logic [31:0] color, input logic [31:0] s,
                                 input logic [31:0] t);
        int addr;
        @(negedge aclk);
        fragmentValid = 1'b1;
        primaryColor = color;
        textureS = s;
        textureT = t;
        // T index in the upper half of the address
        addr = texIndex(t, confTextureClampT) * TEX_SIDE + texIndex(s, confTextureClampS);
        expColors.push_back(refColor(confFunc, texModel[addr], color, confTextureEnvColor));
        expTags.push_back(edgeCount + 1);
        issued++;
    endtask

    task automatic randomFragments(input int n, input logic [31:0] colorFloor);
        for (int i = 0; i < n; i++)
        begin
            issueFragment(nextBits(32) | colorFloor, nextBits(32), nextBits(32));
        end
    endtask

    // Coordinates around the edges of [0, 1.0)
    function automatic logic [31:0] edgeCoord(input int i);
        case (i)
            0: return 32'h00ff8000;
            1: return 32'h00ffffff;
            2: return 32'h00000000;
            3: return 32'h00007fff;
            4: return 32'h00008000;
            5: return 32'hab012345;
            default: return 32'h007fffff;
        endcase
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Test sequence
    ///////////////////////////////////////////////////////////////////////
    initial
    begin
        reset = 1'b1;
        confFunc = rasterPkg::REPLACE;
        confTextureClampS = rasterPkg::REPEAT;
        confTextureClampT = rasterPkg::REPEAT;
        confTextureEnvColor = 32'h0;
        fragmentValid = 1'b0;
        primaryColor = 32'h0;
        textureS = 32'h0;
        textureT = 32'h0;
        texWriteEnable = 1'b0;
        texWriteAddress = 8'h0;
        texWriteData = 32'h0;
        repeat (10) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;

        // Quiet output after reset, texture load meanwhile
        idleCycles(20);
        loadTexture();

        // Wrapping on both axes, above 1.0 and negative included
        for (int i = 0; i < 7; i++)
        begin
            issueFragment(nextBits(32), edgeCoord(i), edgeCoord(6 - i));
        end
        randomFragments(16, 32'h0);

        // One axis clamped, the other wraps
        setConfig(rasterPkg::REPLACE, rasterPkg::CLAMP_TO_EDGE, rasterPkg::REPEAT, 32'h0);
        for (int i = 0; i < 7; i++)
        begin
            issueFragment(nextBits(32), edgeCoord(i), edgeCoord(i));
        end
        randomFragments(8, 32'h0);
        setConfig(rasterPkg::REPLACE, rasterPkg::REPEAT, rasterPkg::CLAMP_TO_EDGE, 32'h0);
        for (int i = 0; i < 7; i++)
        begin
            issueFragment(nextBits(32), edgeCoord(i), edgeCoord(i));
        end
        randomFragments(8, 32'h0);

        setConfig(rasterPkg::MODULATE, rasterPkg::REPEAT, rasterPkg::REPEAT, 32'h0);
        randomFragments(20, 32'h0);
        setConfig(rasterPkg::DECAL, rasterPkg::REPEAT, rasterPkg::REPEAT, 32'h0);
        randomFragments(20, 32'h0);
        setConfig(rasterPkg::BLEND, rasterPkg::REPEAT, rasterPkg::REPEAT, nextBits(32));
        randomFragments(20, 32'h0);
        // High primary channels push most sums past 255
        setConfig(rasterPkg::ADD, rasterPkg::REPEAT, rasterPkg::REPEAT, 32'h0);
        randomFragments(20, 32'h80808080);

        // Back to back burst, then fragments with gaps
        setConfig(rasterPkg::MODULATE, rasterPkg::CLAMP_TO_EDGE, rasterPkg::REPEAT, 32'h0);
        randomFragments(30, 32'h0);
        for (int i = 0; i < 10; i++)
        begin
            idleCycles(i % 4 + 1);
            randomFragments(1, 32'h0);
        end
        waitDrain();
        idleCycles(LAT + 2);

        assert (resultCount == issued)
        else
        begin
            errors++;
            $display("Only %0d results came out for %0d issued fragments", resultCount, issued);
        end
        $display("Checks: %0d, fragments: %0d, errors: %0d", checks, issued, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- vlog.f
rasterPkg.sv
ValueDelay.sv
TextureMemory.sv
TexEnv.sv
TextureMappingUnit.sv
FragmentShadingUnit.sv
tbFragmentShading.sv

//--- runSim.sh
#!/bin/sh
# Compile and run the fragment shading testbench with Verilator.
# Exits with status 0 only when the testbench reports a pass.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tbFragmentShading

output=$(./obj_dir/VtbFragmentShading)
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
